// File: boothController.sv
`timescale 1ns/100ps

module boothController (
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,
    input  logic [1:0]          boothOperation,  // Q0 and the extra bit
    input  logic                stepsDone,
    input  logic                outReady,
    output logic                inReady,
    output logic                outValid,
    output boothPkg::boothCtrl_t ctrl
);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        PROCESS = 2'b01,
        WAIT    = 2'b10,
        DONE    = 2'b11
    } state_e;

    state_e currentState;
    state_e nextState;
    boothPkg::accOp_e stepOp;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            currentState <= IDLE;
        end else begin
            currentState <= nextState;
        end
    end

    // Booth recoding of the current bit pair
    always_comb begin
        case (boothOperation)
            2'b01:   stepOp = boothPkg::ACC_ADD;
            2'b10:   stepOp = boothPkg::ACC_SUB;
            default: stepOp = boothPkg::ACC_HOLD;  // 00 and 11 keep A
        endcase
    end

    always_comb begin
        nextState = currentState;
        case (currentState)
            IDLE: begin
                if (inValid) begin
                    nextState = PROCESS;
                end
            end
            PROCESS: begin
                if (stepsDone && outReady) begin
                    nextState = DONE;  // Consumer already waiting
                end else if (stepsDone) begin
                    nextState = WAIT;
                end
            end
            WAIT: begin
                if (outReady) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_comb begin
        inReady               = 1'b0;
        outValid              = 1'b0;
        ctrl.enable           = 1'b0;
        ctrl.selectMultiplier = 1'b1;
        ctrl.enableProduct    = 1'b0;
        ctrl.accOp            = boothPkg::ACC_HOLD;
        case (currentState)
            IDLE: begin
                inReady               = 1'b1;
                ctrl.selectMultiplier = 1'b0;
                ctrl.enable           = inValid;  // Load on the accepting edge
            end
            PROCESS: begin
                if (stepsDone) begin
                    outValid           = 1'b1;
                    ctrl.enableProduct = 1'b1;  // Word is final, capture it
                end else begin
                    ctrl.enable = 1'b1;
                    ctrl.accOp  = stepOp;
                end
            end
            WAIT: begin
                outValid = 1'b1;  // Hold result under back-pressure
            end
            default: begin
                // DONE, one idle cycle before new operands
            end
        endcase
    end

endmodule

// File: boothDatapath.sv
`timescale 1ns/100ps

module boothDatapath (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic signed [boothPkg::DATA_WIDTH-1:0] multiplicand,
    input  logic signed [boothPkg::DATA_WIDTH-1:0] multiplier,
    input  boothPkg::boothCtrl_t                  ctrl,
    output logic [1:0]                            boothOperation,
    output boothPkg::product_u                    product
);

    localparam int W = boothPkg::DATA_WIDTH;

    logic signed [W-1:0] multiplicandReg;  // M
    boothPkg::product_u  work;             // A and Q
    logic                accGuard;         // Sign bit above A
    logic                extraBit;         // Q(-1)

    logic [W:0]          accWide;          // Guard bit and A
    logic [W:0]          mulWide;          // M sign extended
    logic [W:0]          accNext;
    boothPkg::product_u  shifted;
    logic                shiftedGuard;
    logic                shiftedExtra;
    boothPkg::product_u  productReg;

    // One extra bit on A so that subtracting the most negative M cannot overflow
    assign accWide = {accGuard, work.half.acc};
    assign mulWide = {multiplicandReg[W-1], multiplicandReg};

    // Add or subtract M in the upper half only
    always_comb begin
        case (ctrl.accOp)
            boothPkg::ACC_ADD: accNext = accWide + mulWide;
            boothPkg::ACC_SUB: accNext = accWide - mulWide;
            default:           accNext = accWide;
        endcase
    end

    // Arithmetic right shift of guard, A, Q and the extra bit as one word
    always_comb begin
        shiftedGuard = accNext[W];                        // Sign stays put
        shifted.word = {accNext, work.half.mulq[W-1:1]};
        shiftedExtra = work.half.mulq[0];                 // Q0 drops into the extra bit
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            multiplicandReg <= '0;
            work            <= '0;
            accGuard        <= 1'b0;
            extraBit        <= 1'b0;
        end else if (ctrl.enable) begin
            if (!ctrl.selectMultiplier) begin
                multiplicandReg <= multiplicand;
                work.half.acc   <= '0;
                work.half.mulq  <= multiplier;
                accGuard        <= 1'b0;
                extraBit        <= 1'b0;
            end else begin
                work     <= shifted;
                accGuard <= shiftedGuard;
                extraBit <= shiftedExtra;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            productReg <= '0;
        end else if (ctrl.enableProduct) begin
            productReg <= work;
        end
    end

    assign boothOperation = {work.half.mulq[0], extraBit};

    // The first valid cycle shows the word before the register catches up,
    // so the output is the same value for every cycle of outValid
    assign product = ctrl.enableProduct ? work : productReg;

endmodule

// File: boothMultiplier.sv
`timescale 1ns/100ps

module boothMultiplier (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      inValid,
    input  logic signed [boothPkg::DATA_WIDTH-1:0]     multiplicand,
    input  logic signed [boothPkg::DATA_WIDTH-1:0]     multiplier,
    input  logic                                      outReady,
    output logic                                      inReady,
    output logic                                      outValid,
    output logic signed [2*boothPkg::DATA_WIDTH-1:0]   product
);

    boothPkg::boothCtrl_t ctrl;
    boothPkg::product_u   productWord;
    logic [1:0]           boothOperation;  // Q0 and the extra bit
    logic                 stepsDone;

    boothController boothController_inst (
        .clk            (clk),
        .reset          (reset),
        .inValid        (inValid),
        .boothOperation (boothOperation),
        .stepsDone      (stepsDone),
        .outReady       (outReady),
        .inReady        (inReady),
        .outValid       (outValid),
        .ctrl           (ctrl)
    );

    iterationCounter iterationCounter_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .stepsDone (stepsDone)
    );

    boothDatapath boothDatapath_inst (
        .clk            (clk),
        .reset          (reset),
        .multiplicand   (multiplicand),
        .multiplier     (multiplier),
        .ctrl           (ctrl),
        .boothOperation (boothOperation),
        .product        (productWord)
    );

    // Whole-word view of the product
    assign product = productWord.word;

endmodule

// File: boothPkg.sv
package boothPkg;

    // Operand width, the product is twice as wide
    localparam int DATA_WIDTH = 16;

    // One Booth step per multiplier bit
    localparam int STEP_COUNT = DATA_WIDTH;

    // Accumulator operation for one Booth step
    typedef enum logic [1:0] {
        ACC_HOLD = 2'b00,   // Pair 00 or 11
        ACC_ADD  = 2'b01,   // Pair 01, A + M
        ACC_SUB  = 2'b10    // Pair 10, A - M
    } accOp_e;

    // Control word from the FSM to the counter and the datapath
    typedef struct packed {
        logic   enable;            // Register update strobe
        logic   selectMultiplier;  // 0 load operands, 1 Booth step
        logic   enableProduct;     // Product capture strobe
        accOp_e accOp;             // Add, subtract or hold on A
    } boothCtrl_t;

    // Two halves of the working word
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] acc;   // Accumulator A
        logic        [DATA_WIDTH-1:0] mulq;  // Shifting multiplier Q
    } productHalves_t;

    // The working word is read whole for the shift and by halves for the add
    typedef union packed {
        logic signed [2*DATA_WIDTH-1:0] word;
        productHalves_t                 half;
    } product_u;

endpackage

// File: filelist.f
+incdir+.
boothPkg.sv
boothController.sv
iterationCounter.sv
boothDatapath.sv
boothMultiplier.sv
tbBoothMultiplier.sv

// File: iterationCounter.sv
`timescale 1ns/100ps

module iterationCounter (
    input  logic                 clk,
    input  logic                 reset,
    input  boothPkg::boothCtrl_t ctrl,
    output logic                 stepsDone
);

    localparam int CountWidth = $clog2(boothPkg::STEP_COUNT + 1);

    logic [CountWidth-1:0] count;
    logic                  loadStrobe;
    logic                  stepStrobe;

    assign loadStrobe = ctrl.enable && !ctrl.selectMultiplier;
    assign stepStrobe = ctrl.enable && ctrl.selectMultiplier;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (loadStrobe) begin
            count <= '0;  // New operands restart the count
        end else if (stepStrobe) begin
            count <= count + 1'b1;
        end
    end

    // Stays high until the next load
    assign stepsDone = (count == CountWidth'(boothPkg::STEP_COUNT));

endmodule

// File: runSim.sh
#!/bin/bash
# Builds and runs the Booth multiplier testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing -f filelist.f \
    --top-module tbBoothMultiplier -o simBooth

./obj_dir/simBooth | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "Booth multiplier run succeeded"
    exit 0
else
    echo "Booth multiplier run reported errors, see sim.log"
    exit 1
fi

// File: tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One test entry, the expected product is derived in the testbench
typedef struct packed {
    logic signed [boothPkg::DATA_WIDTH-1:0] multiplicand;
    logic signed [boothPkg::DATA_WIDTH-1:0] multiplier;
    logic        [7:0]                      readyDelay;  // Cycles outReady stays low
} vector_t;

localparam int CORNER_COUNT = 12;
localparam int RANDOM_COUNT = 40;
localparam int VECTOR_COUNT = CORNER_COUNT + RANDOM_COUNT;

// Multiplicand, multiplier, outReady delay
localparam vector_t CORNER_VECTORS [CORNER_COUNT] = '{
    '{16'sh0000, 16'sh1234, 8'd0},   // Zero times a value
    '{16'sh5A5A, 16'sh0000, 8'd2},   // A value times zero
    '{16'sh0001, 16'sh0001, 8'd0},   // One times one
    '{16'sh0001, 16'sh7FFF, 8'd0},
    '{16'shFFFF, 16'sh0001, 8'd0},   // Minus one times one
    '{16'shFFFF, 16'shFFFF, 8'd3},   // Minus one squared
    '{16'sh8000, 16'sh8000, 8'd5},   // Most negative squared
    '{16'sh8000, 16'sh0001, 8'd0},   // Most negative times one
    '{16'sh0001, 16'sh8000, 8'd1},
    '{16'sh7FFF, 16'sh7FFF, 8'd0},
    '{16'sh7FFF, 16'sh8000, 8'd4},
    '{16'shFFFF, 16'sh8000, 8'd0}
};

`endif

// File: tbBoothMultiplier.sv
`timescale 1ns/100ps

module tbBoothMultiplier;

    `include "tbVectors.svh"

    localparam int W             = boothPkg::DATA_WIDTH;
    localparam int LATENCY       = 17;  // Accepting edge to first outValid cycle
    localparam int READY_TIMEOUT = 40;
    localparam int VALID_TIMEOUT = 40;

    logic                  clk;
    logic                  reset;
    logic                  inValid;
    logic signed [W-1:0]   multiplicand;
    logic signed [W-1:0]   multiplier;
    logic                  outReady;
    logic                  inReady;
    logic                  outValid;
    logic signed [2*W-1:0] product;

    vector_t vectors [VECTOR_COUNT];
    integer  seed;
    int      mismatchCount;
    int      timeoutCount;
    int      idx;
    logic    timedOut;

    boothMultiplier boothMultiplier_inst (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .outReady     (outReady),
        .inReady      (inReady),
        .outValid     (outValid),
        .product      (product)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        mismatchCount++;
        $display("Mismatch: %s got %h expected %h at %0t", name, got, expected, $time);
    endtask

    // Corner entries first, then random pairs
    task automatic fillTable();
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < CORNER_COUNT; i++) begin
            vectors[i] = CORNER_VECTORS[i];
        end
        for (i = CORNER_COUNT; i < VECTOR_COUNT; i++) begin
            rnd = $random(seed);
            vectors[i].multiplicand = rnd[W-1:0];
            rnd = $random(seed);
            vectors[i].multiplier = rnd[W-1:0];
            vectors[i].readyDelay = rnd[18] ? {6'd0, rnd[17:16]} : 8'd0;  // Half back-to-back
        end
    endtask

    task automatic waitForReady();
        int cycles;
        cycles = 0;
        while (!inReady && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!inReady) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("Timeout: inReady did not rise within %0d cycles", READY_TIMEOUT);
        end
    endtask

    task automatic applyEntry(input vector_t entry);
        logic signed [2*W-1:0] expA;
        logic signed [2*W-1:0] expB;
        logic signed [2*W-1:0] expected;
        logic [31:0]           junk;
        int                    cycles;
        int                    held;
        logic                  seen;
        expA = {{W{entry.multiplicand[W-1]}}, entry.multiplicand};
        expB = {{W{entry.multiplier[W-1]}}, entry.multiplier};
        expected = expA * expB;  // Signed 32-bit product
        waitForReady();
        if (!timedOut) begin
            multiplicand = entry.multiplicand;
            multiplier   = entry.multiplier;
            inValid      = 1'b1;
            @(posedge clk);  // Accepting edge
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < VALID_TIMEOUT) begin
                @(negedge clk);
                cycles++;
                if (outValid) begin
                    seen = 1'b1;
                end else begin
                    if (inReady !== 1'b0) begin
                        reportMismatch("inReady", 32'(inReady), 32'd0);
                    end
                    // Garbage operands and stray valid pulses while busy
                    junk         = $random(seed);
                    multiplicand = junk[W-1:0];
                    multiplier   = junk[2*W-1:W];
                    inValid      = (cycles == 4) || (cycles == 9);
                end
            end
            if (!seen) begin
                timeoutCount++;
                timedOut = 1'b1;
                $display("Timeout: outValid did not rise within %0d cycles", VALID_TIMEOUT);
            end else begin
                if (cycles != LATENCY) begin
                    reportMismatch("latency", cycles, LATENCY);
                end
                if (product !== expected) begin
                    reportMismatch("product", product, expected);
                end
                // Consumer stalls, result must hold
                for (held = 0; held < int'(entry.readyDelay); held++) begin
                    @(negedge clk);
                    if (outValid !== 1'b1) begin
                        reportMismatch("outValid", 32'(outValid), 32'd1);
                    end
                    if (product !== expected) begin
                        reportMismatch("product", product, expected);
                    end
                end
                outReady = 1'b1;
                @(negedge clk);
                outReady = 1'b0;
                if (outValid !== 1'b0) begin
                    reportMismatch("outValid", 32'(outValid), 32'd0);
                end
            end
        end
    endtask

    initial begin
        seed          = 21;
        mismatchCount = 0;
        timeoutCount  = 0;
        timedOut      = 1'b0;
        reset         = 1'b0;
        inValid       = 1'b0;
        multiplicand  = '0;
        multiplier    = '0;
        outReady      = 1'b0;
        fillTable();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        if (inReady !== 1'b1) begin
            reportMismatch("inReady", 32'(inReady), 32'd1);
        end
        if (outValid !== 1'b0) begin
            reportMismatch("outValid", 32'(outValid), 32'd0);
        end
        idx = 0;
        while (idx < VECTOR_COUNT && !timedOut) begin
            applyEntry(vectors[idx]);
            idx++;
        end
        $display("Report: %0d of %0d entries applied, %0d mismatches, %0d timeouts",
                 idx, VECTOR_COUNT, mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
